// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f src.f --top-module rv_exec_tb -o rv_exec_sim
	./obj_dir/rv_exec_sim | tee /dev/stderr | grep -q "Simulation PASSED"

clean:
	rm -rf obj_dir

// ==== dv/rv_exec_sva.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv_exec_consts.svh"

module rv_exec_sva (
  input wire                   clk_i,
  input wire                   rst_n_i,
  input wire                   inst_valid_i,
  input wire                   result_valid_o,
  input wire                   wb_we,
  input wire [`REG_ADDR_W-1:0] wb_rd
);

  // accept edge plus writeback edge, so the result shows two edges on
  result_latency: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    result_valid_o == $past(inst_valid_i, 2))
    else $error("result_valid_o does not follow inst_valid_i by two edges");

  quiet_in_reset: assert property (@(posedge clk_i) !rst_n_i |-> !result_valid_o)
    else $error("result_valid_o high during reset");

  no_x0_write: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    wb_we |-> wb_rd != '0)
    else $error("register file write enabled for x0");

endmodule

bind rv_exec_top rv_exec_sva i_sva (
  .clk_i, .rst_n_i, .inst_valid_i, .result_valid_o, .wb_we, .wb_rd
);

`default_nettype wire

// ==== dv/rv_exec_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_exec_tb;

  localparam int ISSUE_BUDGET = 120; // upper bound on issue slots over all tests

  logic        clk_i;
  logic        rst_n_i;
  logic        inst_valid_i;
  logic [31:0] inst_i;
  logic [31:0] pc_i;
  wire         result_valid_o;
  wire  [4:0]  result_rd_o;
  wire  [31:0] result_o;

  logic [31:0] regs_m [32];
  logic [31:0] instret_m;
  logic [31:0] pc_m;
  logic [31:0] captured [$];
  int          seed = 38;
  int          errors;
  int          checks;
  int          tests;
  // expected outputs for the instructions one and two slots back
  logic        p1_v, p2_v, p1_cap, p2_cap;
  logic [4:0]  p1_rd, p2_rd;
  logic [31:0] p1_d, p2_d;

  rv_exec_top i_dut (
    .clk_i, .rst_n_i, .inst_valid_i, .inst_i, .pc_i,
    .result_valid_o, .result_rd_o, .result_o
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  initial begin
    #(ISSUE_BUDGET * 3 * 4 + 50 * 4);
    $display("watchdog expired before the tests completed");
    $display("Simulation FAILED");
    $finish;
  end

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAILED at time %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  function automatic logic [31:0] enc_r(input logic alt, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [4:0] rd);
    return {1'b0, alt, 5'b0, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd,
                                        input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
  endfunction

  // ISA semantics of the OP and OP-IMM groups
  function automatic logic [31:0] alu_model(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
    case (f3)
      3'b000:  return alt ? a - b : a + b;
      3'b001:  return a << b[4:0];
      3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'b011:  return (a < b) ? 32'd1 : 32'd0;
      3'b100:  return a ^ b;
      3'b101:  return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'b110:  return a | b;
      default: return a & b;
    endcase
  endfunction

  // one issue slot; the outputs seen here belong to the slot two back
  task automatic step(input logic v, input logic [31:0] inst, input logic [4:0] rd,
                      input logic [31:0] d, input logic cap);
    @(negedge clk_i);
    check("result_valid_o", {31'b0, result_valid_o}, {31'b0, p2_v});
    if (p2_v) begin
      check("result_rd_o", {27'b0, result_rd_o}, {27'b0, p2_rd});
      if (p2_cap) captured.push_back(result_o);
      else check("result_o", result_o, p2_d);
    end
    p2_v = p1_v;
    p2_rd = p1_rd;
    p2_d = p1_d;
    p2_cap = p1_cap;
    p1_v = v;
    p1_rd = rd;
    p1_d = d;
    p1_cap = cap;
    inst_valid_i = v;
    inst_i = inst;
    pc_i = pc_m;
    if (v) pc_m = pc_m + 32'd4;
  endtask

  task automatic issue(input logic [31:0] inst, input logic [4:0] rd, input logic [31:0] value,
                       input logic retires, input logic cap);
    if (retires) instret_m = instret_m + 32'd1;
    if (retires && rd != 5'd0) regs_m[rd] = value;
    step(1'b1, inst, rd, value, cap);
  endtask

  task automatic drain();
    repeat (2) step(1'b0, 32'h0, 5'd0, 32'h0, 1'b0);
  endtask

  task automatic do_rr(input logic [2:0] f3, input logic alt, input logic [4:0] rd,
                       input logic [4:0] rs1, input logic [4:0] rs2);
    issue(enc_r(alt, rs2, rs1, f3, rd), rd, alu_model(f3, alt, regs_m[rs1], regs_m[rs2]),
          1'b1, 1'b0);
  endtask

  task automatic do_ri(input logic [2:0] f3, input logic [4:0] rd, input logic [4:0] rs1,
                       input logic [11:0] imm);
    logic alt;
    alt = (f3 == 3'b101) && imm[10];
    issue(enc_i(imm, rs1, f3, rd, 7'b0010011), rd,
          alu_model(f3, alt, regs_m[rs1], {{20{imm[11]}}, imm}), 1'b1, 1'b0);
  endtask

  task automatic load_value(input logic [4:0] rd, input logic [31:0] v);
    logic [19:0] upper;
    upper = v[31:12] + {19'b0, v[11]}; // addi sign-extends its low part
    issue({upper, rd, 7'b0110111}, rd, {upper, 12'h000}, 1'b1, 1'b0);
    do_ri(3'b000, rd, rd, v[11:0]);
  endtask

  task automatic finish_test(input string name, input int err_before);
    tests++;
    $display("test %-10s %s", name, (errors == err_before) ? "ok" : "had errors");
  endtask

  task automatic test_rr_ops();
    int e;
    e = errors;
    load_value(5'd1, $random(seed));
    load_value(5'd2, $random(seed));
    load_value(5'd3, 32'd5);
    load_value(5'd4, 32'd9);
    load_value(5'd5, 32'hFFFF_FFFD);
    load_value(5'd6, 32'h8000_00F3);
    load_value(5'd7, 32'h0000_0125); // only the low five bits shift
    for (int f = 0; f < 8; f++) do_rr(f[2:0], 1'b0, 5'(10 + f), 5'd1, 5'd2);
    do_rr(3'b000, 1'b1, 5'd18, 5'd1, 5'd2);
    do_rr(3'b000, 1'b1, 5'd19, 5'd3, 5'd4); // underflow
    do_rr(3'b010, 1'b0, 5'd20, 5'd5, 5'd4);
    do_rr(3'b011, 1'b0, 5'd21, 5'd5, 5'd4);
    do_rr(3'b010, 1'b0, 5'd22, 5'd4, 5'd5);
    do_rr(3'b011, 1'b0, 5'd23, 5'd4, 5'd5);
    do_rr(3'b101, 1'b1, 5'd24, 5'd6, 5'd7);
    do_rr(3'b101, 1'b0, 5'd25, 5'd6, 5'd7);
    drain();
    finish_test("reg_reg", e);
  endtask

  task automatic test_imm_ops();
    int e;
    e = errors;
    do_ri(3'b100, 5'd13, 5'd1, 12'hFFF);
    do_ri(3'b110, 5'd14, 5'd2, 12'h800);
    do_ri(3'b111, 5'd15, 5'd1, 12'h7F0);
    do_ri(3'b010, 5'd16, 5'd5, 12'hFFE);
    do_ri(3'b011, 5'd17, 5'd4, 12'hFFF);
    do_ri(3'b001, 5'd18, 5'd6, 12'd5);
    do_ri(3'b101, 5'd19, 5'd6, 12'd7);
    do_ri(3'b101, 5'd20, 5'd6, {7'b0100000, 5'd9});
    drain();
    finish_test("reg_imm", e);
  endtask

  task automatic test_dependent();
    int e;
    e = errors;
    do_ri(3'b000, 5'd21, 5'd0, 12'd7);
    do_rr(3'b000, 1'b0, 5'd22, 5'd21, 5'd21);
    do_rr(3'b000, 1'b1, 5'd23, 5'd22, 5'd21);
    do_ri(3'b001, 5'd21, 5'd23, 12'd3);
    do_rr(3'b100, 1'b0, 5'd22, 5'd21, 5'd22);
    drain();
    finish_test("dependent", e);
  endtask

  task automatic test_jumps();
    int e;
    e = errors;
    issue({20'h12345, 5'd24, 7'b0010111}, 5'd24, pc_m + 32'h1234_5000, 1'b1, 1'b0);
    issue(enc_j(21'd12, 5'd25), 5'd25, pc_m + 32'd4, 1'b1, 1'b0);
    issue(enc_i(12'd0, 5'd1, 3'b000, 5'd26, 7'b1100111), 5'd26, pc_m + 32'd4, 1'b1, 1'b0);
    drain();
    finish_test("jumps", e);
  endtask

  task automatic test_x0_and_nop();
    int e;
    e = errors;
    do_ri(3'b000, 5'd0, 5'd1, 12'd5); // the result shows while x0 keeps zero
    do_rr(3'b000, 1'b0, 5'd27, 5'd0, 5'd0);
    // a load is outside the subset and retires nothing
    issue(enc_i(12'd0, 5'd1, 3'b010, 5'd7, 7'b0000011), 5'd7, 32'h0, 1'b0, 1'b0);
    do_rr(3'b000, 1'b0, 5'd28, 5'd7, 5'd0);
    drain();
    finish_test("x0_nop", e);
  endtask

  task automatic test_counters();
    int e;
    e = errors;
    issue(enc_i(12'hC02, 5'd0, 3'b010, 5'd29, 7'b1110011), 5'd29, instret_m, 1'b1, 1'b0);
    drain();
    captured.delete();
    issue(enc_i(12'hC00, 5'd0, 3'b010, 5'd30, 7'b1110011), 5'd30, 32'h0, 1'b1, 1'b1);
    repeat (4) step(1'b0, 32'h0, 5'd0, 32'h0, 1'b0);
    issue(enc_i(12'hC00, 5'd0, 3'b010, 5'd31, 7'b1110011), 5'd31, 32'h0, 1'b1, 1'b1);
    drain();
    if (captured.size() != 2) begin
      errors++;
      $display("expected two cycle counter reads but saw %0d", captured.size());
    end else begin
      check("cycle delta", captured[1] - captured[0], 32'd5);
    end
    finish_test("counters", e);
  endtask

  initial begin
    rst_n_i = 1'b0;
    inst_valid_i = 1'b0;
    inst_i = 32'h0;
    pc_i = 32'h0;
    pc_m = 32'h0000_1000;
    instret_m = 32'h0;
    errors = 0;
    checks = 0;
    tests = 0;
    {p1_v, p2_v, p1_cap, p2_cap} = 4'b0;
    {p1_rd, p2_rd, p1_d, p2_d} = '0;
    for (int i = 0; i < 32; i++) regs_m[i] = 32'h0;
    repeat (4) @(posedge clk_i);
    @(negedge clk_i);
    rst_n_i = 1'b1;
    test_rr_ops();
    test_imm_ops();
    test_dependent();
    test_jumps();
    test_x0_and_nop();
    test_counters();
    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+verilog
verilog/rv_exec_pkg.sv
verilog/rv_decoder.sv
verilog/rv_regfile.sv
verilog/rv_csr_counters.sv
verilog/fu.sv
verilog/rv_writeback.sv
verilog/rv_exec_top.sv
dv/rv_exec_sva.sv
dv/rv_exec_tb.sv

// ==== verilog/fu.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv_exec_consts.svh"

module fu (
  input  rv_exec_pkg::inst_type_e inst_type_i,
  input  rv_exec_pkg::alu_op_e    alu_op_i,
  input  logic [`XLEN-1:0]        pc_i,
  input  logic [`XLEN-1:0]        imm_i,
  input  logic [`XLEN-1:0]        rdata1_i,
  input  logic [`XLEN-1:0]        rdata2_i,
  input  logic [`XLEN-1:0]        csr_i,
  output logic [`XLEN-1:0]        alu_result_o
);

  logic             is_nop;
  logic [`XLEN-1:0] operand1;
  logic [`XLEN-1:0] operand2;
  logic [4:0]       shamt;

  assign is_nop = (inst_type_i == rv_exec_pkg::INST_NOP) ||
                  (alu_op_i == rv_exec_pkg::ALU_OP_NOP);

  always_comb begin
    operand1 = '0;
    operand2 = '0;
    if (!is_nop) begin
      case (inst_type_i)
        rv_exec_pkg::INST_RR: begin
          operand1 = rdata1_i;
          operand2 = rdata2_i;
        end
        rv_exec_pkg::INST_RI: begin
          operand1 = rdata1_i;
          operand2 = imm_i;
        end
        rv_exec_pkg::INST_LUI:   operand2 = imm_i; // operand1 stays zero
        rv_exec_pkg::INST_AUIPC: begin
          operand1 = pc_i;
          operand2 = imm_i;
        end
        rv_exec_pkg::INST_JAL,
        rv_exec_pkg::INST_JALR:  operand1 = pc_i;
        rv_exec_pkg::INST_CSRR:  operand1 = csr_i;
        default: ;
      endcase
    end
  end

  assign shamt = operand2[4:0];

  always_comb begin
    case (alu_op_i)
      rv_exec_pkg::ALU_OP_ADD,
      rv_exec_pkg::ALU_OP_LUI,
      rv_exec_pkg::ALU_OP_AUIPC: alu_result_o = operand1 + operand2;
      rv_exec_pkg::ALU_OP_SUB:   alu_result_o = operand1 - operand2;
      rv_exec_pkg::ALU_OP_XOR:   alu_result_o = operand1 ^ operand2;
      rv_exec_pkg::ALU_OP_OR:    alu_result_o = operand1 | operand2;
      rv_exec_pkg::ALU_OP_AND:   alu_result_o = operand1 & operand2;
      rv_exec_pkg::ALU_OP_SLL:   alu_result_o = operand1 << shamt;
      rv_exec_pkg::ALU_OP_SRL:   alu_result_o = operand1 >> shamt;
      rv_exec_pkg::ALU_OP_SRA:   alu_result_o = $unsigned($signed(operand1) >>> shamt);
      rv_exec_pkg::ALU_OP_SLT:
        alu_result_o = {{(`XLEN-1){1'b0}}, $signed(operand1) < $signed(operand2)};
      rv_exec_pkg::ALU_OP_SLTU:
        alu_result_o = {{(`XLEN-1){1'b0}}, operand1 < operand2};
      rv_exec_pkg::ALU_OP_JUMP:  alu_result_o = operand1 + `XLEN'd4; // link address
      rv_exec_pkg::ALU_OP_CSRR:  alu_result_o = operand1;
      default:                   alu_result_o = '0;
    endcase
    if (is_nop) begin
      alu_result_o = '0;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/rv_csr_counters.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv_exec_consts.svh"

module rv_csr_counters (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   retire_i,
  input  logic [`CSR_ADDR_W-1:0] addr_i,
  output logic [`XLEN-1:0]       rdata_o
);

  logic [`XLEN-1:0] cycle_q;
  logic [`XLEN-1:0] instret_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cycle_q   <= '0;
      instret_q <= '0;
    end else begin
      cycle_q <= cycle_q + `XLEN'd1; // free running and wraps silently
      if (retire_i) begin
        instret_q <= instret_q + `XLEN'd1;
      end
    end
  end

  // reads see the count from before this edge's increment
  always_comb begin
    case (addr_i)
      `CSR_CYCLE:   rdata_o = cycle_q;
      `CSR_INSTRET: rdata_o = instret_q;
      default:      rdata_o = '0;
    endcase
  end

endmodule

`default_nettype wire

// ==== verilog/rv_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv_exec_consts.svh"

module rv_decoder (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  logic                      inst_valid_i,
  input  logic [31:0]               inst_i,
  input  logic [`XLEN-1:0]          pc_i,
  output logic                      valid_o,
  output rv_exec_pkg::inst_type_e   type_o,
  output rv_exec_pkg::alu_op_e      op_o,
  output logic [`REG_ADDR_W-1:0]    rs1_o,
  output logic [`REG_ADDR_W-1:0]    rs2_o,
  output logic [`REG_ADDR_W-1:0]    rd_o,
  output logic [`XLEN-1:0]          imm_o,
  output logic [`XLEN-1:0]          pc_o,
  output logic [`CSR_ADDR_W-1:0]    csr_addr_o
);

  // major opcodes of the supported subset
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

  logic [31:0]      inst_q;
  logic [6:0]       opcode;
  logic [2:0]       funct3;
  logic [6:0]       funct7;
  logic [`XLEN-1:0] imm_i_type;
  logic [`XLEN-1:0] imm_u_type;
  logic [`XLEN-1:0] imm_j_type;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_o <= 1'b0;
    end else begin
      valid_o <= inst_valid_i;
    end
  end

  // the word and pc only move when a new instruction arrives
  always_ff @(posedge clk_i) begin
    if (inst_valid_i) begin
      inst_q <= inst_i;
      pc_o   <= pc_i;
    end
  end

  assign opcode     = inst_q[6:0];
  assign funct3     = inst_q[14:12];
  assign funct7     = inst_q[31:25];
  assign rd_o       = inst_q[11:7];
  assign rs1_o      = inst_q[19:15];
  assign rs2_o      = inst_q[24:20];
  assign csr_addr_o = inst_q[31:20];

  assign imm_i_type = {{20{inst_q[31]}}, inst_q[31:20]};
  assign imm_u_type = {inst_q[31:12], 12'h000};
  assign imm_j_type = {{12{inst_q[31]}}, inst_q[19:12], inst_q[20], inst_q[30:21], 1'b0};

  always_comb begin
    type_o = rv_exec_pkg::INST_NOP;
    op_o   = rv_exec_pkg::ALU_OP_NOP;
    imm_o  = '0;
    case (opcode)
      OPC_OP: begin
        if (funct7 == 7'b0000000) begin
          type_o = rv_exec_pkg::INST_RR;
          case (funct3)
            3'b000:  op_o = rv_exec_pkg::ALU_OP_ADD;
            3'b001:  op_o = rv_exec_pkg::ALU_OP_SLL;
            3'b010:  op_o = rv_exec_pkg::ALU_OP_SLT;
            3'b011:  op_o = rv_exec_pkg::ALU_OP_SLTU;
            3'b100:  op_o = rv_exec_pkg::ALU_OP_XOR;
            3'b101:  op_o = rv_exec_pkg::ALU_OP_SRL;
            3'b110:  op_o = rv_exec_pkg::ALU_OP_OR;
            default: op_o = rv_exec_pkg::ALU_OP_AND;
          endcase
        end else if (funct7 == 7'b0100000 && funct3 == 3'b000) begin
          type_o = rv_exec_pkg::INST_RR;
          op_o   = rv_exec_pkg::ALU_OP_SUB;
        end else if (funct7 == 7'b0100000 && funct3 == 3'b101) begin
          type_o = rv_exec_pkg::INST_RR;
          op_o   = rv_exec_pkg::ALU_OP_SRA;
        end
      end
      OPC_OP_IMM: begin
        type_o = rv_exec_pkg::INST_RI;
        imm_o  = imm_i_type; // shamt sits in the low five bits
        case (funct3)
          3'b000: op_o = rv_exec_pkg::ALU_OP_ADD;
          3'b010: op_o = rv_exec_pkg::ALU_OP_SLT;
          3'b011: op_o = rv_exec_pkg::ALU_OP_SLTU;
          3'b100: op_o = rv_exec_pkg::ALU_OP_XOR;
          3'b110: op_o = rv_exec_pkg::ALU_OP_OR;
          3'b111: op_o = rv_exec_pkg::ALU_OP_AND;
          3'b001: begin
            if (funct7 == 7'b0000000) op_o = rv_exec_pkg::ALU_OP_SLL;
          end
          default: begin
            if (funct7 == 7'b0000000) op_o = rv_exec_pkg::ALU_OP_SRL;
            else if (funct7 == 7'b0100000) op_o = rv_exec_pkg::ALU_OP_SRA;
          end
        endcase
        // a bad shift encoding falls back to a nop
        if (op_o == rv_exec_pkg::ALU_OP_NOP) begin
          type_o = rv_exec_pkg::INST_NOP;
          imm_o  = '0;
        end
      end
      OPC_LUI: begin
        type_o = rv_exec_pkg::INST_LUI;
        op_o   = rv_exec_pkg::ALU_OP_LUI;
        imm_o  = imm_u_type;
      end
      OPC_AUIPC: begin
        type_o = rv_exec_pkg::INST_AUIPC;
        op_o   = rv_exec_pkg::ALU_OP_AUIPC;
        imm_o  = imm_u_type;
      end
      OPC_JAL: begin
        type_o = rv_exec_pkg::INST_JAL;
        op_o   = rv_exec_pkg::ALU_OP_JUMP;
        imm_o  = imm_j_type;
      end
      OPC_JALR: begin
        if (funct3 == 3'b000) begin
          type_o = rv_exec_pkg::INST_JALR;
          op_o   = rv_exec_pkg::ALU_OP_JUMP;
          imm_o  = imm_i_type;
        end
      end
      OPC_SYSTEM: begin
        // only csrrs rd, csr, x0 is a pure counter read
        if (funct3 == 3'b010 && rs1_o == '0) begin
          type_o = rv_exec_pkg::INST_CSRR;
          op_o   = rv_exec_pkg::ALU_OP_CSRR;
        end
      end
      default: ;
    endcase
  end

endmodule

`default_nettype wire

// ==== verilog/rv_exec_consts.svh ====
`ifndef RV_EXEC_CONSTS_SVH
`define RV_EXEC_CONSTS_SVH

// data path and pc width
`define XLEN 32

// register file geometry
`define REG_ADDR_W 5
`define NUM_REGS   32

// counter CSRs reachable through CSRRS
`define CSR_ADDR_W  12
`define CSR_CYCLE   12'hC00
`define CSR_INSTRET 12'hC02

`endif

// ==== verilog/rv_exec_pkg.sv ====
`default_nettype none

package rv_exec_pkg;

  // instruction class that picks the operand sources in the fu
  typedef enum logic [2:0] {
    INST_NOP   = 3'd0,
    INST_RR    = 3'd1,
    INST_RI    = 3'd2,
    INST_LUI   = 3'd3,
    INST_AUIPC = 3'd4,
    INST_JAL   = 3'd5,
    INST_JALR  = 3'd6,
    INST_CSRR  = 3'd7
  } inst_type_e;

  typedef enum logic [3:0] {
    ALU_OP_NOP   = 4'd0,
    ALU_OP_ADD   = 4'd1,
    ALU_OP_SUB   = 4'd2,
    ALU_OP_XOR   = 4'd3,
    ALU_OP_OR    = 4'd4,
    ALU_OP_AND   = 4'd5,
    ALU_OP_SLL   = 4'd6,
    ALU_OP_SRL   = 4'd7,
    ALU_OP_SRA   = 4'd8,
    ALU_OP_SLT   = 4'd9,
    ALU_OP_SLTU  = 4'd10,
    ALU_OP_LUI   = 4'd11,
    ALU_OP_AUIPC = 4'd12,
    ALU_OP_JUMP  = 4'd13, // link value for jal and jalr
    ALU_OP_CSRR  = 4'd14
  } alu_op_e;

endpackage

`default_nettype wire

// ==== verilog/rv_exec_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv_exec_consts.svh"

module rv_exec_top (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   inst_valid_i,
  input  logic [31:0]            inst_i,
  input  logic [`XLEN-1:0]       pc_i,
  output logic                   result_valid_o,
  output logic [`REG_ADDR_W-1:0] result_rd_o,
  output logic [`XLEN-1:0]       result_o
);

  logic                    dec_valid;
  rv_exec_pkg::inst_type_e dec_type;
  rv_exec_pkg::alu_op_e    dec_op;
  logic [`REG_ADDR_W-1:0]  dec_rs1;
  logic [`REG_ADDR_W-1:0]  dec_rs2;
  logic [`REG_ADDR_W-1:0]  dec_rd;
  logic [`XLEN-1:0]        dec_imm;
  logic [`XLEN-1:0]        dec_pc;
  logic [`CSR_ADDR_W-1:0]  dec_csr_addr;

  logic [`XLEN-1:0]        rdata1;
  logic [`XLEN-1:0]        rdata2;
  logic [`XLEN-1:0]        csr_rdata;
  logic [`XLEN-1:0]        alu_result;

  logic                    wb_valid;
  logic                    wb_we;
  logic [`REG_ADDR_W-1:0]  wb_rd;
  logic [`XLEN-1:0]        wb_data;
  logic                    retire;

  rv_decoder u_decoder (
    .clk_i, .rst_n_i, .inst_valid_i, .inst_i, .pc_i,
    .valid_o(dec_valid), .type_o(dec_type), .op_o(dec_op),
    .rs1_o(dec_rs1), .rs2_o(dec_rs2), .rd_o(dec_rd),
    .imm_o(dec_imm), .pc_o(dec_pc), .csr_addr_o(dec_csr_addr)
  );

  rv_regfile u_regfile (
    .clk_i, .rst_n_i,
    .raddr1_i(dec_rs1), .raddr2_i(dec_rs2), .rdata1_o(rdata1), .rdata2_o(rdata2),
    .we_i(wb_we), .waddr_i(wb_rd), .wdata_i(wb_data)
  );

  rv_csr_counters u_csr (
    .clk_i, .rst_n_i, .retire_i(retire), .addr_i(dec_csr_addr), .rdata_o(csr_rdata)
  );

  fu u_fu (
    .inst_type_i(dec_type), .alu_op_i(dec_op), .pc_i(dec_pc), .imm_i(dec_imm),
    .rdata1_i(rdata1), .rdata2_i(rdata2), .csr_i(csr_rdata), .alu_result_o(alu_result)
  );

  rv_writeback u_wb (
    .clk_i, .rst_n_i,
    .valid_i(dec_valid), .type_i(dec_type), .rd_i(dec_rd), .result_i(alu_result),
    .valid_o(wb_valid), .we_o(wb_we), .rd_o(wb_rd), .data_o(wb_data), .retire_o(retire)
  );

  assign result_valid_o = wb_valid;
  assign result_rd_o    = wb_rd;
  assign result_o       = wb_data;

endmodule

`default_nettype wire

// ==== verilog/rv_regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv_exec_consts.svh"

module rv_regfile (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic [`REG_ADDR_W-1:0] raddr1_i,
  input  logic [`REG_ADDR_W-1:0] raddr2_i,
  output logic [`XLEN-1:0]       rdata1_o,
  output logic [`XLEN-1:0]       rdata2_o,
  input  logic                   we_i,
  input  logic [`REG_ADDR_W-1:0] waddr_i,
  input  logic [`XLEN-1:0]       wdata_i
);

  logic [`XLEN-1:0] regs [`NUM_REGS];

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < `NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we_i && waddr_i != '0) begin
      regs[waddr_i] <= wdata_i;
    end
  end

  // a pending write shows through so the next instruction sees it this cycle
  assign rdata1_o = (raddr1_i == '0)                    ? '0      :
                    (we_i && waddr_i == raddr1_i)       ? wdata_i : regs[raddr1_i];
  assign rdata2_o = (raddr2_i == '0)                    ? '0      :
                    (we_i && waddr_i == raddr2_i)       ? wdata_i : regs[raddr2_i];

endmodule

`default_nettype wire

// ==== verilog/rv_writeback.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv_exec_consts.svh"

module rv_writeback (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  logic                    valid_i,
  input  rv_exec_pkg::inst_type_e type_i,
  input  logic [`REG_ADDR_W-1:0]  rd_i,
  input  logic [`XLEN-1:0]        result_i,
  output logic                    valid_o,
  output logic                    we_o,
  output logic [`REG_ADDR_W-1:0]  rd_o,
  output logic [`XLEN-1:0]        data_o,
  output logic                    retire_o
);

  logic retiring;

  assign retiring = valid_i && (type_i != rv_exec_pkg::INST_NOP);

  // instret counts at the edge where the result is captured
  assign retire_o = retiring;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_o <= 1'b0;
      we_o    <= 1'b0;
    end else begin
      valid_o <= valid_i; // nops still show up with a zero result
      we_o    <= retiring && (rd_i != '0);
    end
  end

  always_ff @(posedge clk_i) begin
    if (valid_i) begin
      rd_o   <= rd_i;
      data_o <= result_i;
    end
  end

endmodule

`default_nettype wire
